/* build.f */
src/mm_cfg_pkg.sv
src/mm_bus_pkg.sv
src/row_to_block_conv.sv
src/matmul_engine.sv
src/block_to_row_conv.sv
src/matmul_top.sv
testbench/tb_clock_gen.sv
testbench/matmul_checker.sv
testbench/matmul_tb.sv

/* Makefile */
# Verilator flow for the matrix multiply subsystem

TB_TOP = matmul_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/matmul_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Matrix multiply subsystem testbench
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module matmul_tb;

    localparam int n_tests    = 6;
    localparam int max_cycles = n_tests * 400;

    logic                 clk;
    logic                 rst_n;
    logic                 en;
    logic                 i_req;
    mm_bus_pkg::i_row_t   i_row;
    logic                 i_ack;
    logic                 w_req;
    mm_bus_pkg::w_row_t   w_row;
    logic                 w_ack;
    logic                 o_req;
    mm_bus_pkg::out_row_t o_data;
    logic                 o_ack;
    logic                 done;
    int                   errors;
    int                   checked;

    // Test table, one entry per run
    mm_bus_pkg::i_row_t i_tab [n_tests][mm_cfg_pkg::i_rows];
    mm_bus_pkg::w_row_t w_tab [n_tests][mm_cfg_pkg::inner_dim];
    int                 dly_tab  [n_tests] = '{0, 1, 0, 6, 0, 2};
    bit                 drop_tab [n_tests] = '{0, 0, 0, 0, 0, 1};

    int seed      = 32'h8958;
    int cycles    = 0;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    matmul_top matmul_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .i_req  (i_req),
        .i_row  (i_row),
        .i_ack  (i_ack),
        .w_req  (w_req),
        .w_row  (w_row),
        .w_ack  (w_ack),
        .o_req  (o_req),
        .o_data (o_data),
        .o_ack  (o_ack),
        .done   (done)
    );

    matmul_checker chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .i_ack   (i_ack),
        .i_row   (i_row),
        .w_ack   (w_ack),
        .w_row   (w_row),
        .o_req   (o_req),
        .o_data  (o_data),
        .done    (done),
        .errors  (errors),
        .checked (checked)
    );

    task automatic build_table();
        for (int t = 0; t < n_tests; t++) begin
            for (int r = 0; r < mm_cfg_pkg::i_rows; r++) begin
                for (int k = 0; k < mm_cfg_pkg::inner_dim; k++) begin
                    i_tab[t][r].e[k] = mm_bus_pkg::elem_t'($random(seed) % 2048);
                end
            end
            for (int k = 0; k < mm_cfg_pkg::inner_dim; k++) begin
                for (int c = 0; c < mm_cfg_pkg::w_cols; c++) begin
                    w_tab[t][k].e[c] = mm_bus_pkg::elem_t'($random(seed) % 2048);
                end
            end
        end
        for (int r = 0; r < mm_cfg_pkg::i_rows; r++) begin
            for (int k = 0; k < mm_cfg_pkg::inner_dim; k++) begin
                // Entry 0 signed values, entry 1 small fractions, entry 2 huge
                i_tab[0][r].e[k] = mm_bus_pkg::elem_t'((r * 3 + k - 5) * 96);
                i_tab[1][r].e[k] = mm_bus_pkg::elem_t'((r - 2) * 200 + k * 75 - 60);
                i_tab[2][r].e[k] = (r % 2 == 1) ? 16'shC000 : 16'sh4000;
            end
        end
        for (int k = 0; k < mm_cfg_pkg::inner_dim; k++) begin
            for (int c = 0; c < mm_cfg_pkg::w_cols; c++) begin
                // Identity weights, random fractions near +-2.0, saturating weights
                w_tab[0][k].e[c] = (k == c) ? 16'sh0100 : 16'sh0000;
                w_tab[1][k].e[c] = mm_bus_pkg::elem_t'($random(seed) % 512);
                w_tab[2][k].e[c] = 16'sh4000;
            end
        end
    endtask

    task automatic send_i_row(input mm_bus_pkg::i_row_t row);
        i_row = row;
        i_req = 1'b1;
        do begin
            @(posedge clk);
        end while (!i_ack);
        #1 i_req = 1'b0;
        do begin
            @(posedge clk);
        end while (i_ack);
        #1;
    endtask

    task automatic send_w_row(input mm_bus_pkg::w_row_t row);
        w_row = row;
        w_req = 1'b1;
        do begin
            @(posedge clk);
        end while (!w_ack);
        #1 w_req = 1'b0;
        do begin
            @(posedge clk);
        end while (w_ack);
        #1;
    endtask

    // Output side acknowledge with the delay of the test being drained
    initial begin : ack_proc
        o_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (o_req && !o_ack) begin
                repeat (dly_tab[checked]) @(posedge clk);
                #1 o_ack = 1'b1;
                do begin
                    @(posedge clk);
                end while (o_req);
                #1 o_ack = 1'b0;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, a result never finished", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin : stim
        en    = 1'b0;
        i_req = 1'b0;
        w_req = 1'b0;
        i_row = '0;
        w_row = '0;
        build_table();
        @(posedge rst_n);
        @(posedge clk);
        #1 en = 1'b1;

        for (int t = 0; t < n_tests; t++) begin
            if (drop_tab[t]) begin
                // Earlier results drain before the abort
                while (checked < t) begin
                    @(posedge clk);
                    #1;
                end
                // Partial load of other data, then abort it
                send_i_row(mm_bus_pkg::i_row_t'(~i_tab[t][0]));
                send_i_row(mm_bus_pkg::i_row_t'(~i_tab[t][1]));
                en = 1'b0;
                repeat (2) @(posedge clk);
                #1 en = 1'b1;
            end
            // Next load waits on the full flags while the previous one drains
            fork
                for (int r = 0; r < mm_cfg_pkg::i_rows; r++) begin
                    send_i_row(i_tab[t][r]);
                end
                for (int k = 0; k < mm_cfg_pkg::inner_dim; k++) begin
                    send_w_row(w_tab[t][k]);
                end
            join
        end

        while (checked < n_tests) begin
            @(posedge clk);
            #1;
        end

        repeat (2) @(posedge clk);
        if (checked != n_tests) begin
            $display("Error: %0d results checked, %0d tests run", checked, n_tests);
        end
        $display("Tests run %0d, checked %0d, errors %0d", n_tests, checked, errors);
        if (errors == 0 && checked == n_tests) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* testbench/matmul_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Result checker with Q8.8 reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module matmul_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 i_ack,
    input  mm_bus_pkg::i_row_t   i_row,
    input  logic                 w_ack,
    input  mm_bus_pkg::w_row_t   w_row,
    input  logic                 o_req,
    input  mm_bus_pkg::out_row_t o_data,
    input  logic                 done,
    output int                   errors,
    output int                   checked
);

    mm_bus_pkg::i_row_t   i_q [$];
    mm_bus_pkg::w_row_t   w_q [$];
    mm_bus_pkg::out_row_t o_q [$];

    logic i_ack_q;
    logic w_ack_q;
    logic o_req_q;
    int   err_cnt = 0;
    int   test_cnt = 0;

    assign errors  = err_cnt;
    assign checked = test_cnt;

    // One product element, 32-bit sum, shift by 8 then clamp
    function automatic mm_bus_pkg::elem_t q88_elem(input int r, input int c);
        int acc;
        int sh;
        acc = 0;
        for (int k = 0; k < mm_cfg_pkg::inner_dim; k++) begin
            acc = acc + int'(i_q[r].e[k]) * int'(w_q[k].e[c]);
        end
        sh = acc >>> mm_cfg_pkg::frac_width;
        if (sh > mm_cfg_pkg::data_max) begin
            sh = mm_cfg_pkg::data_max;
        end else if (sh < mm_cfg_pkg::data_min) begin
            sh = mm_cfg_pkg::data_min;
        end
        return mm_bus_pkg::elem_t'(sh);
    endfunction

    task automatic check_result();
        mm_bus_pkg::out_row_t exp_row;
        int bad;
        bad = 0;
        if (i_q.size() != mm_cfg_pkg::i_rows || w_q.size() != mm_cfg_pkg::inner_dim) begin
            $display("Error at %0t: done seen with %0d I rows and %0d W rows loaded",
                     $time, i_q.size(), w_q.size());
            bad++;
        end else begin
            if (o_q.size() != mm_cfg_pkg::i_rows) begin
                $display("Error at %0t: %0d result rows returned, expected %0d",
                         $time, o_q.size(), mm_cfg_pkg::i_rows);
                bad++;
            end
            for (int r = 0; r < mm_cfg_pkg::i_rows && r < o_q.size(); r++) begin
                // Last flag only on the final row
                exp_row.last = (r == mm_cfg_pkg::i_rows - 1);
                for (int c = 0; c < mm_cfg_pkg::w_cols; c++) begin
                    exp_row.row.e[c] = q88_elem(r, c);
                end
                if (o_q[r] !== exp_row) begin
                    $display("FAIL at %0t: o_data row %0d expected %h got %h",
                             $time, r, exp_row, o_q[r]);
                    bad++;
                end
            end
        end
        err_cnt += bad;
        $display("test %0d %s at %0t: %0d result rows, %0d errors",
                 test_cnt, (bad == 0) ? "ok" : "failed", $time, o_q.size(), bad);
        test_cnt++;
        i_q.delete();
        w_q.delete();
        o_q.delete();
    endtask

    always @(posedge clk) begin
        if (!rst_n || !en) begin
            // Aborted loads are forgotten
            i_q.delete();
            w_q.delete();
            o_q.delete();
            i_ack_q <= 1'b0;
            w_ack_q <= 1'b0;
            o_req_q <= 1'b0;
        end else begin
            if (i_ack && !i_ack_q) begin
                if (i_q.size() == mm_cfg_pkg::i_rows) begin
                    $display("Error at %0t: I row accepted before done", $time);
                    err_cnt++;
                end else begin
                    i_q.push_back(i_row);
                end
            end
            if (w_ack && !w_ack_q) begin
                if (w_q.size() == mm_cfg_pkg::inner_dim) begin
                    $display("Error at %0t: W row accepted before done", $time);
                    err_cnt++;
                end else begin
                    w_q.push_back(w_row);
                end
            end
            // Row is stable from the first cycle of o_req
            if (o_req && !o_req_q) begin
                o_q.push_back(o_data);
            end
            if (done) begin
                check_result();
            end
            i_ack_q <= i_ack;
            w_ack_q <= w_ack;
            o_req_q <= o_req;
        end
    end

endmodule

/* testbench/tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* src/matmul_top.sv */
////////////////////////////////////////////////////////////////////////////
// Matrix multiply subsystem
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module matmul_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,

    // Input matrix I, one row per handshake
    input  logic                 i_req,
    input  mm_bus_pkg::i_row_t   i_row,
    output logic                 i_ack,

    // Weight matrix W, one row per handshake
    input  logic                 w_req,
    input  mm_bus_pkg::w_row_t   w_row,
    output logic                 w_ack,

    // Product rows
    output logic                 o_req,
    output mm_bus_pkg::out_row_t o_data,
    input  logic                 o_ack,
    output logic                 done
);

    mm_bus_pkg::i_wr_t    i_wr;
    mm_bus_pkg::w_wr_t    w_wr;
    logic                 full_i;
    logic                 full_w;
    logic                 res_valid;
    mm_bus_pkg::res_row_t res_row;
    logic                 res_last;
    logic                 res_taken;
    logic                 buf_release;

    row_to_block_conv #(
        .row_t (mm_bus_pkg::i_row_t),
        .wr_t  (mm_bus_pkg::i_wr_t),
        .rows  (mm_cfg_pkg::i_rows)
    ) i_conv (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .req         (i_req),
        .row         (i_row),
        .ack         (i_ack),
        .wr          (i_wr),
        .full        (full_i),
        .buf_release (buf_release)
    );

    row_to_block_conv #(
        .row_t (mm_bus_pkg::w_row_t),
        .wr_t  (mm_bus_pkg::w_wr_t),
        .rows  (mm_cfg_pkg::inner_dim)
    ) w_conv (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .req         (w_req),
        .row         (w_row),
        .ack         (w_ack),
        .wr          (w_wr),
        .full        (full_w),
        .buf_release (buf_release)
    );

    matmul_engine engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .i_wr      (i_wr),
        .w_wr      (w_wr),
        .full_i    (full_i),
        .full_w    (full_w),
        .res_valid (res_valid),
        .res_row   (res_row),
        .res_last  (res_last),
        .res_taken (res_taken)
    );

    block_to_row_conv out_conv (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .res_valid   (res_valid),
        .res_row     (res_row),
        .res_last    (res_last),
        .res_taken   (res_taken),
        .o_req       (o_req),
        .o_data      (o_data),
        .o_ack       (o_ack),
        .done        (done),
        .buf_release (buf_release)
    );

endmodule

/* src/block_to_row_conv.sv */
////////////////////////////////////////////////////////////////////////////
// Result rows to four-phase output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module block_to_row_conv (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,

    // Engine side
    input  logic                 res_valid,
    input  mm_bus_pkg::res_row_t res_row,
    input  logic                 res_last,
    output logic                 res_taken,

    // Four-phase row output
    output logic                 o_req,
    output mm_bus_pkg::out_row_t o_data,
    input  logic                 o_ack,

    output logic                 done,
    output logic                 buf_release
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK
    } state_t;

    state_t state;

    // Row stays stable while o_req is high
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && res_valid) begin
            o_data.last <= res_last;
            o_data.row  <= res_row;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            state       <= ST_IDLE;
            done        <= 1'b0;
            buf_release <= 1'b0;
        end else begin
            done        <= 1'b0;
            buf_release <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (res_valid) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (o_ack) begin
                        state <= ST_ACK;
                    end
                end
                // Handshake closes once ack falls
                ST_ACK: begin
                    if (!o_ack) begin
                        state <= ST_IDLE;
                        if (o_data.last) begin
                            done        <= 1'b1;
                            buf_release <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign o_req     = (state == ST_REQ);
    // Advances the engine on the same edge the handshake closes
    assign res_taken = (state == ST_ACK) && !o_ack;

endmodule

/* src/matmul_engine.sv */
////////////////////////////////////////////////////////////////////////////
// Sequential Q8.8 matrix multiply engine
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module matmul_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,

    // Buffer writes from the row converters
    input  mm_bus_pkg::i_wr_t    i_wr,
    input  mm_bus_pkg::w_wr_t    w_wr,
    input  logic                 full_i,
    input  logic                 full_w,

    // Result rows
    output logic                 res_valid,
    output mm_bus_pkg::res_row_t res_row,
    output logic                 res_last,
    input  logic                 res_taken
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAC,
        ST_WB,
        ST_OUT
    } state_t;

    state_t state;
    logic   both_full_q;
    logic   start;

    mm_bus_pkg::i_row_t   i_buf   [mm_cfg_pkg::i_rows];
    mm_bus_pkg::w_row_t   w_buf   [mm_cfg_pkg::inner_dim];
    mm_bus_pkg::res_row_t res_buf [mm_cfg_pkg::i_rows];

    logic [mm_cfg_pkg::i_addr_width-1:0] row_idx;
    logic [mm_cfg_pkg::col_width-1:0]    col_idx;
    logic [mm_cfg_pkg::w_addr_width-1:0] k_idx;

    logic signed [mm_cfg_pkg::acc_width-1:0] acc;
    logic signed [mm_cfg_pkg::acc_width-1:0] prod;
    logic signed [mm_cfg_pkg::acc_width-1:0] shifted;
    mm_bus_pkg::elem_t                       a_elem;
    mm_bus_pkg::elem_t                       b_elem;
    mm_bus_pkg::elem_t                       sat_elem;

    // Input buffers
    always_ff @(posedge clk) begin
        if (i_wr.we) begin
            i_buf[i_wr.addr] <= i_wr.row;
        end
        if (w_wr.we) begin
            w_buf[w_wr.addr] <= w_wr.row;
        end
    end

    // Start on the first cycle with both matrices complete
    assign start = full_i && full_w && !both_full_q;

    always_comb begin
        a_elem  = i_buf[row_idx].e[k_idx];
        b_elem  = w_buf[k_idx].e[col_idx];
        prod    = a_elem * b_elem;
        shifted = acc >>> mm_cfg_pkg::frac_width;

        if (shifted > mm_cfg_pkg::data_max) begin
            sat_elem = mm_bus_pkg::elem_t'(mm_cfg_pkg::data_max);
        end else if (shifted < mm_cfg_pkg::data_min) begin
            sat_elem = mm_bus_pkg::elem_t'(mm_cfg_pkg::data_min);
        end else begin
            sat_elem = mm_bus_pkg::elem_t'(shifted);
        end
    end

    // Accumulator and result buffer
    always_ff @(posedge clk) begin
        if (state == ST_MAC) begin
            if (k_idx == '0) begin
                acc <= prod;
            end else begin
                acc <= acc + prod;
            end
        end
        if (state == ST_WB) begin
            res_buf[row_idx].e[col_idx] <= sat_elem;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            state       <= ST_IDLE;
            both_full_q <= 1'b0;
            row_idx     <= '0;
            col_idx     <= '0;
            k_idx       <= '0;
        end else begin
            both_full_q <= full_i && full_w;

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        row_idx <= '0;
                        col_idx <= '0;
                        k_idx   <= '0;
                        state   <= ST_MAC;
                    end
                end

                ST_MAC: begin
                    if (k_idx == mm_cfg_pkg::k_last) begin
                        k_idx <= '0;
                        state <= ST_WB;
                    end else begin
                        k_idx <= k_idx + 1'b1;
                    end
                end

                // Element written back, move to the next one
                ST_WB: begin
                    state <= ST_MAC;
                    if (col_idx == mm_cfg_pkg::col_last) begin
                        col_idx <= '0;
                        if (row_idx == mm_cfg_pkg::i_last) begin
                            row_idx <= '0;
                            state   <= ST_OUT;
                        end else begin
                            row_idx <= row_idx + 1'b1;
                        end
                    end else begin
                        col_idx <= col_idx + 1'b1;
                    end
                end

                ST_OUT: begin
                    if (res_taken) begin
                        if (row_idx == mm_cfg_pkg::i_last) begin
                            row_idx <= '0;
                            state   <= ST_IDLE;
                        end else begin
                            row_idx <= row_idx + 1'b1;
                        end
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Row index doubles as the output row pointer
    assign res_valid = (state == ST_OUT);
    assign res_row   = res_buf[row_idx];
    assign res_last  = (row_idx == mm_cfg_pkg::i_last);

endmodule

/* src/row_to_block_conv.sv */
////////////////////////////////////////////////////////////////////////////
// Row intake to buffer writes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module row_to_block_conv #(
    parameter type row_t = mm_bus_pkg::i_row_t,
    parameter type wr_t  = mm_bus_pkg::i_wr_t,
    parameter int  rows  = mm_cfg_pkg::i_rows
) (
    input  logic clk,
    input  logic rst_n,
    input  logic en,

    // Four-phase row input
    input  logic req,
    input  row_t row,
    output logic ack,

    // Buffer side
    output wr_t  wr,
    output logic full,
    input  logic buf_release
);

    localparam int addr_width = $clog2(rows);
    localparam logic [addr_width-1:0] cnt_last = addr_width'(rows - 1);

    logic [addr_width-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            ack   <= 1'b0;
            full  <= 1'b0;
            cnt   <= '0;
            wr.we <= 1'b0;
        end else begin
            // Strobe lasts one cycle
            wr.we <= 1'b0;

            if (req && !ack && !full) begin
                // New row, write it and acknowledge
                ack     <= 1'b1;
                wr.we   <= 1'b1;
                wr.addr <= cnt;
                wr.row  <= row;
                if (cnt == cnt_last) begin
                    cnt  <= '0;
                    full <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (ack && !req) begin
                ack <= 1'b0;
            end

            // Output side has drained the product
            if (buf_release) begin
                full <= 1'b0;
            end
        end
    end

endmodule

/* src/mm_bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Matrix multiply bus types
////////////////////////////////////////////////////////////////////////////
package mm_bus_pkg;

    typedef logic signed [mm_cfg_pkg::data_width-1:0] elem_t;

    // Element 0 sits in the low bits of each row
    typedef struct packed {
        elem_t [mm_cfg_pkg::inner_dim-1:0] e;
    } i_row_t;

    typedef struct packed {
        elem_t [mm_cfg_pkg::w_cols-1:0] e;
    } w_row_t;

    typedef struct packed {
        elem_t [mm_cfg_pkg::w_cols-1:0] e;
    } res_row_t;

    // Buffer write ports
    typedef struct packed {
        logic                                we;
        logic [mm_cfg_pkg::i_addr_width-1:0] addr;
        i_row_t                              row;
    } i_wr_t;

    typedef struct packed {
        logic                                we;
        logic [mm_cfg_pkg::w_addr_width-1:0] addr;
        w_row_t                              row;
    } w_wr_t;

    // Outgoing result row
    typedef struct packed {
        logic     last;
        res_row_t row;
    } out_row_t;

endpackage

/* src/mm_cfg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Matrix multiply configuration
////////////////////////////////////////////////////////////////////////////
package mm_cfg_pkg;

    // Matrix shapes, result is i_rows x w_cols
    localparam int i_rows    = 4;
    localparam int inner_dim = 3;
    localparam int w_cols    = 4;

    // Signed Q8.8 elements
    localparam int data_width = 16;
    localparam int frac_width = 8;
    localparam int acc_width  = 32;

    // Row addresses of the I and W buffers
    localparam int i_addr_width = $clog2(i_rows);
    localparam int w_addr_width = $clog2(inner_dim);
    // Column index within a W or result row
    localparam int col_width = $clog2(w_cols);

    // Last index of each loop
    localparam logic [i_addr_width-1:0] i_last   = i_addr_width'(i_rows - 1);
    localparam logic [w_addr_width-1:0] k_last   = w_addr_width'(inner_dim - 1);
    localparam logic [col_width-1:0]    col_last = col_width'(w_cols - 1);

    // Clamp bounds of a 16-bit signed result
    localparam int data_max = (2 ** (data_width - 1)) - 1;
    localparam int data_min = -(2 ** (data_width - 1));

endpackage
